// ==== alu_pkg.sv ====
`default_nettype none

package alu_pkg;

    // Widest operand the board supports
    localparam int ALU_MAX_W = 5;

    // Function code width, as on the MIPS funct field
    localparam int ALU_OP_W = 6;

    // Switch word width on the board
    localparam int SW_W = 16;

    // MIPS-style function codes
    typedef enum logic [ALU_OP_W-1:0] {
        // Arithmetic, signed overflow reported
        OP_ADD = 6'b100000,
        OP_SUB = 6'b100010,
        // Bitwise
        OP_AND = 6'b100100,
        OP_OR  = 6'b100101,
        OP_XOR = 6'b100110,
        OP_NOR = 6'b100111,
        // Shifts of A by B
        OP_SRA = 6'b000011,
        OP_SRL = 6'b000010
    } alu_op_e;

    // Everything the ALU needs for one computation
    // Only the low N bits of a and b carry data
    typedef struct packed {
        logic [ALU_MAX_W-1:0] a;
        logic [ALU_MAX_W-1:0] b;
        alu_op_e              op;
    } alu_operands_t;

    // Value after reset, op left at an undefined code
    localparam alu_operands_t ALU_OPERANDS_RESET = '{
        a:  '0,
        b:  '0,
        op: alu_op_e'(6'b000000)
    };

endpackage

`default_nettype wire

// ==== button_pulse.sv ====
`timescale 1ns/10ps
`default_nettype none

module button_pulse #(
    parameter int WIDTH = 3
) (
    input  wire logic             i_clock,
    input  wire logic             i_reset,
    input  wire logic [WIDTH-1:0] i_btn,
    output logic      [WIDTH-1:0] o_pulse
);

    // First synchroniser stage which may go metastable
    logic [WIDTH-1:0] sync_q1;
    // Second stage is safe to use in logic
    logic [WIDTH-1:0] sync_q2;
    // Level seen one cycle earlier
    logic [WIDTH-1:0] prev_q;

    // Buttons are asynchronous to the clock
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            sync_q1 <= '0;
            sync_q2 <= '0;
            prev_q  <= '0;
        end
        else
        begin
            sync_q1 <= i_btn;
            sync_q2 <= sync_q1;
            prev_q  <= sync_q2;
        end
    end

    // Rising edge of the synchronised level
    // High on the second edge after the press is sampled
    always_comb
    begin
        o_pulse = sync_q2 & ~prev_q;
    end

    // A held button must give a single pulse
    a_single_cycle_pulse : assert property (
        @(posedge i_clock) disable iff (i_reset)
        (o_pulse & $past(o_pulse)) == '0
    )
    else
        $error("button_pulse: pulse held for two cycles");

endmodule

`default_nettype wire

// ==== alu_input_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_input_ctrl
    import alu_pkg::*;
#(
    parameter int N = 4
) (
    input  wire logic          i_clock,
    input  wire logic          i_reset,
    input  wire logic [SW_W-1:0] i_sw,
    input  wire logic          i_load_a,
    input  wire logic          i_load_b,
    input  wire logic          i_load_op,
    output alu_operands_t      o_operands,
    output logic               o_start,
    output logic               o_result_valid
);

    // Stored operands with upper bits beyond N held at zero
    alu_operands_t operands_q;
    // Request for the ALU one cycle after the op pulse
    logic          start_q;
    // Result on the LEDs belongs to the stored operands
    logic          valid_q;

    // Switch fields packed as {op, B, A} with A at bit 0
    logic [N-1:0]        sw_a;
    logic [N-1:0]        sw_b;
    logic [ALU_OP_W-1:0] sw_op;

    always_comb
    begin
        sw_a  = i_sw[N-1:0];
        sw_b  = i_sw[2*N-1:N];
        sw_op = i_sw[2*N +: ALU_OP_W];
    end

    // Each register follows only its own button
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            operands_q <= ALU_OPERANDS_RESET;
        end
        else
        begin
            if (i_load_a)
            begin
                operands_q.a <= ALU_MAX_W'(sw_a);
            end
            if (i_load_b)
            begin
                operands_q.b <= ALU_MAX_W'(sw_b);
            end
            // Unknown codes pass through and the ALU zeroes them
            if (i_load_op)
            begin
                operands_q.op <= alu_op_e'(sw_op);
            end
        end
    end

    // Start and valid sequencing
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            start_q <= 1'b0;
            valid_q <= 1'b0;
        end
        else
        begin
            start_q <= i_load_op;
            // New operand invalidates the shown result
            if (i_load_a || i_load_b)
            begin
                valid_q <= 1'b0;
            end
            // ALU result lands on this same edge
            else if (start_q)
            begin
                valid_q <= 1'b1;
            end
        end
    end

    always_comb
    begin
        o_operands     = operands_q;
        o_start        = start_q;
        o_result_valid = valid_q;
    end

    // Start exactly one cycle after the op pulse
    a_start_after_op : assert property (
        @(posedge i_clock) disable iff (i_reset)
        o_start == $past(i_load_op)
    )
    else
        $error("alu_input_ctrl: start not aligned to op pulse");

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu
    import alu_pkg::*;
#(
    parameter int N = 4
) (
    input  wire logic          i_clock,
    input  wire logic          i_reset,
    input  wire alu_operands_t i_operands,
    input  wire logic          i_start,
    output logic [ALU_MAX_W-1:0] o_result,
    output logic               o_overflow
);

    // Shift amounts at or above this saturate
    localparam logic [N:0] SHIFT_LIMIT = (N+1)'(N);

    // Working operands, N bits wide
    logic [N-1:0] op_a;
    logic [N-1:0] op_b;

    // Arithmetic intermediates
    logic [N-1:0] sum;
    logic [N-1:0] diff;
    logic         sum_ovf;
    logic         diff_ovf;
    logic         shift_sat;

    // Next values for the output registers
    logic [N-1:0] calc_result;
    logic         calc_ovf;

    // Registered outputs and the op that produced them
    logic [ALU_MAX_W-1:0] result_q;
    logic                 ovf_q;
    alu_op_e              op_q;

    always_comb
    begin
        op_a = i_operands.a[N-1:0];
        op_b = i_operands.b[N-1:0];
        sum  = op_a + op_b;
        diff = op_a - op_b;
        // Same-sign inputs, result sign flipped
        sum_ovf  = (op_a[N-1] == op_b[N-1]) && (sum[N-1] != op_a[N-1]);
        // Opposite-sign inputs, result takes the sign of B
        diff_ovf = (op_a[N-1] != op_b[N-1]) && (diff[N-1] != op_a[N-1]);
        shift_sat = {1'b0, op_b} >= SHIFT_LIMIT;
    end

    // Operation decode
    always_comb
    begin
        calc_result = '0;
        calc_ovf    = 1'b0;
        case (i_operands.op)
            OP_ADD:
            begin
                calc_result = sum;
                calc_ovf    = sum_ovf;
            end
            OP_SUB:
            begin
                calc_result = diff;
                calc_ovf    = diff_ovf;
            end
            OP_AND: calc_result = op_a & op_b;
            OP_OR:  calc_result = op_a | op_b;
            OP_XOR: calc_result = op_a ^ op_b;
            OP_NOR: calc_result = ~(op_a | op_b);
            OP_SRA:
            begin
                // Large shifts fill with the sign bit
                if (shift_sat)
                    calc_result = {N{op_a[N-1]}};
                else
                    calc_result = $unsigned($signed(op_a) >>> op_b);
            end
            OP_SRL:
            begin
                if (shift_sat)
                    calc_result = '0;
                else
                    calc_result = op_a >> op_b;
            end
            // Undefined code, zero with no flag
            default:
            begin
                calc_result = '0;
                calc_ovf    = 1'b0;
            end
        endcase
    end

    // Capture only on start, hold otherwise
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            result_q <= '0;
            ovf_q    <= 1'b0;
            op_q     <= alu_op_e'(6'b000000);
        end
        else if (i_start)
        begin
            result_q <= ALU_MAX_W'(calc_result);
            ovf_q    <= calc_ovf;
            op_q     <= i_operands.op;
        end
    end

    always_comb
    begin
        o_result   = result_q;
        o_overflow = ovf_q;
    end

    // Flag belongs to arithmetic only
    a_ovf_only_arith : assert property (
        @(posedge i_clock) disable iff (i_reset)
        o_overflow |-> (op_q == OP_ADD || op_q == OP_SUB)
    )
    else
        $error("alu: overflow set for a non-arithmetic op");

endmodule

`default_nettype wire

// ==== alu_board_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_board_top
    import alu_pkg::*;
#(
    parameter int N = 4
) (
    input  wire logic              i_clock,
    input  wire logic              i_reset,
    input  wire logic [SW_W-1:0]   i_sw,
    input  wire logic              i_btn_a,
    input  wire logic              i_btn_b,
    input  wire logic              i_btn_op,
    output logic [ALU_MAX_W-1:0]   o_led,
    output logic                   o_ovf_led,
    output logic                   o_result_valid
);

    // Button pulses, bit 0 A, bit 1 B, bit 2 op
    logic [2:0]    btn_pulse;
    // Stored operands toward the ALU
    alu_operands_t operands;
    // Compute request
    logic          alu_start;

    // Raw buttons to single-cycle pulses
    button_pulse #(
        .WIDTH (3)
    ) u_button_pulse (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_btn   ({i_btn_op, i_btn_b, i_btn_a}),
        .o_pulse (btn_pulse)
    );

    // Switch fields into operand registers
    alu_input_ctrl #(
        .N (N)
    ) u_alu_input_ctrl (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_sw           (i_sw),
        .i_load_a       (btn_pulse[0]),
        .i_load_b       (btn_pulse[1]),
        .i_load_op      (btn_pulse[2]),
        .o_operands     (operands),
        .o_start        (alu_start),
        .o_result_valid (o_result_valid)
    );

    // Result and flag drive the LEDs directly
    alu #(
        .N (N)
    ) u_alu (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_operands (operands),
        .i_start    (alu_start),
        .o_result   (o_led),
        .o_overflow (o_ovf_led)
    );

endmodule

`default_nettype wire

// ==== alu_board_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_board_checker
    import alu_pkg::*;
#(
    parameter int N      = 4,
    parameter int NAME_W = 96
) (
    input  wire logic                 i_clock,
    input  wire logic                 i_reset,
    input  wire logic                 i_btn_ab,
    input  wire logic [ALU_MAX_W-1:0] i_led,
    input  wire logic                 i_ovf_led,
    input  wire logic                 i_result_valid,
    input  wire alu_operands_t        i_expect,
    input  wire logic [NAME_W-1:0]    i_name,
    output int                        o_checks,
    output int                        o_errors
);

    int                   errors = 0;
    int                   checks = 0;
    // Cycles an A or B button has been held
    int                   press_cycles;
    logic                 in_reset;
    logic                 seen_reset;
    logic                 valid_q;
    // LED state at the previous falling edge
    logic [ALU_MAX_W-1:0] held_led;
    logic                 held_ovf;
    // Overflow on top, result below
    logic [ALU_MAX_W:0]   expected;

    assign o_errors = errors;
    assign o_checks = checks;

    // Reference model on plain integers, signed view of N-bit values
    function automatic logic [ALU_MAX_W:0] expect_result(input alu_operands_t ops);
        int   ua;
        int   ub;
        int   sa;
        int   sb;
        int   full;
        int   res;
        int   half;
        int   span;
        logic ovf;
        half = 1 << (N - 1);
        span = 1 << N;
        ua   = int'(ops.a[N-1:0]);
        ub   = int'(ops.b[N-1:0]);
        sa   = (ua >= half) ? ua - span : ua;
        sb   = (ub >= half) ? ub - span : ub;
        full = 0;
        res  = 0;
        case (ops.op)
            OP_ADD: full = sa + sb;
            OP_SUB: full = sa - sb;
            OP_AND: res = ua & ub;
            OP_OR:  res = ua | ub;
            OP_XOR: res = ua ^ ub;
            OP_NOR: res = ~(ua | ub);
            OP_SRA: res = (ub >= N) ? ((sa < 0) ? -1 : 0) : (sa >>> ub);
            OP_SRL: res = (ub >= N) ? 0 : (ua >> ub);
            default: res = 0;
        endcase
        // True sum outside the signed range of N bits
        ovf = (full >= half) || (full < -half);
        // At most one of the two is nonzero
        res = (res + full) & (span - 1);
        return {ovf, ALU_MAX_W'(res)};
    endfunction

    // Inputs change on falling edges, so count on rising ones
    always @(posedge i_clock)
    begin
        in_reset     <= i_reset;
        press_cycles <= (i_reset || !i_btn_ab) ? 0 : press_cycles + 1;
    end

    always @(negedge i_clock)
    begin
        if (in_reset)
        begin
            seen_reset <= 1'b1;
            valid_q    <= 1'b0;
        end
        else
        begin
            if (seen_reset && (i_result_valid || i_led != '0 || i_ovf_led))
            begin
                $display("Outputs were not cleared by reset");
                errors++;
            end
            // New result
            if (i_result_valid && !valid_q)
            begin
                expected = expect_result(i_expect);
                checks++;
                if (i_led != expected[ALU_MAX_W-1:0])
                begin
                    $display("ERROR %0s result expected %h actual %h",
                             i_name, expected[ALU_MAX_W-1:0], i_led);
                    errors++;
                end
                if (i_ovf_led != expected[ALU_MAX_W])
                begin
                    $display("ERROR %0s overflow expected %b actual %b",
                             i_name, expected[ALU_MAX_W], i_ovf_led);
                    errors++;
                end
            end
            // A shown result must not move while valid holds
            else if (i_result_valid && (i_led != held_led || i_ovf_led != held_ovf))
            begin
                $display("ERROR %0s held result expected %h actual %h",
                         i_name, {held_ovf, held_led}, {i_ovf_led, i_led});
                errors++;
            end
            // Press has passed the synchroniser by now
            if (i_result_valid && press_cycles >= 3)
            begin
                $display("Result valid stayed high after an operand press in %0s", i_name);
                errors++;
            end
            seen_reset <= 1'b0;
            valid_q    <= i_result_valid;
            held_led   <= i_led;
            held_ovf   <= i_ovf_led;
        end
    end

endmodule

`default_nettype wire

// ==== tb_alu_board.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_alu_board
    import alu_pkg::*;
();

    localparam int N         = 4;
    localparam int NAME_W    = 96;
    localparam int NUM_FIXED = 16;
    localparam int NUM_ROWS  = NUM_FIXED + 8;
    localparam int MASK      = (1 << N) - 1;
    localparam int TIMEOUT   = 40;

    // One vector and how its buttons are pressed
    typedef struct packed {
        logic [NAME_W-1:0]    name;
        logic [ALU_MAX_W-1:0] a;
        logic [ALU_MAX_W-1:0] b;
        logic [ALU_OP_W-1:0]  op;
        logic                 load_a;
        logic                 hold_op;
    } row_t;

    logic                 clock;
    logic                 reset;
    logic [SW_W-1:0]      sw;
    logic                 btn_a;
    logic                 btn_b;
    logic                 btn_op;
    logic [ALU_MAX_W-1:0] led;
    logic                 ovf_led;
    logic                 result_valid;
    // Operands the DUT should hold with A kept when not reloaded
    alu_operands_t        expect_ops;
    logic [NAME_W-1:0]    row_name;
    int                   checks;
    int                   errors;
    int                   tb_errors;
    row_t                 table_rows [NUM_ROWS];
    alu_op_e              op_list [8] = '{OP_ADD, OP_SUB, OP_AND, OP_OR,
                                          OP_XOR, OP_NOR, OP_SRA, OP_SRL};

    always #2 clock = ~clock;

    alu_board_top #(
        .N (N)
    ) u_alu_board_top (
        .i_clock        (clock),
        .i_reset        (reset),
        .i_sw           (sw),
        .i_btn_a        (btn_a),
        .i_btn_b        (btn_b),
        .i_btn_op       (btn_op),
        .o_led          (led),
        .o_ovf_led      (ovf_led),
        .o_result_valid (result_valid)
    );

    alu_board_checker #(
        .N      (N),
        .NAME_W (NAME_W)
    ) u_alu_board_checker (
        .i_clock        (clock),
        .i_reset        (reset),
        .i_btn_ab       (btn_a | btn_b),
        .i_led          (led),
        .i_ovf_led      (ovf_led),
        .i_result_valid (result_valid),
        .i_expect       (expect_ops),
        .i_name         (row_name),
        .o_checks       (checks),
        .o_errors       (errors)
    );

    function automatic row_t make_row(input logic [NAME_W-1:0] name, input int a, input int b,
                                      input logic [ALU_OP_W-1:0] op, input logic load_a,
                                      input logic hold_op);
        row_t r;
        r.name    = name;
        r.a       = ALU_MAX_W'(a);
        r.b       = ALU_MAX_W'(b);
        r.op      = op;
        r.load_a  = load_a;
        r.hold_op = hold_op;
        return r;
    endfunction

    // Buttons high for a while and then three idle cycles
    task automatic press(input logic [2:0] buttons, input int hold);
        {btn_op, btn_b, btn_a} = buttons;
        repeat (hold) @(negedge clock);
        {btn_op, btn_b, btn_a} = 3'b000;
        repeat (3) @(negedge clock);
    endtask

    task automatic apply_row(input row_t row);
        int cycles;
        row_name = row.name;
        sw = '0;
        sw[N-1:0] = row.a[N-1:0];
        sw[2*N-1:N] = row.b[N-1:0];
        sw[2*N +: ALU_OP_W] = row.op;
        if (row.load_a)
        begin
            expect_ops.a = row.a;
            press(3'b001, 3);
        end
        expect_ops.b  = row.b;
        expect_ops.op = alu_op_e'(row.op);
        press(3'b010, 3);
        // A long hold must still give one compute
        if (row.hold_op)
        begin
            btn_op = 1'b1;
            repeat (6) @(negedge clock);
            // A second compute would now pick up another op and move the LEDs
            sw[2*N +: ALU_OP_W] = ~row.op;
            press(3'b100, 6);
        end
        else
        begin
            press(3'b100, 3);
        end
        cycles = 0;
        while (!result_valid && cycles < TIMEOUT)
        begin
            @(negedge clock);
            cycles++;
        end
        if (!result_valid)
        begin
            $display("Result never became valid in %0s", row.name);
            tb_errors++;
        end
    endtask

    initial
    begin
        clock      = 1'b0;
        reset      = 1'b1;
        sw         = '0;
        btn_a      = 1'b0;
        btn_b      = 1'b0;
        btn_op     = 1'b0;
        expect_ops = ALU_OPERANDS_RESET;
        row_name   = '0;
        tb_errors  = 0;
        void'($urandom(32'h38c7_5d42));

        // Corner cases where 10 stands for -6 in the shifts
        table_rows[0]  = make_row("add_7_1", 7, 1, OP_ADD, 1'b1, 1'b0);
        table_rows[1]  = make_row("sub_m8_1", 8, 1, OP_SUB, 1'b1, 1'b0);
        table_rows[2]  = make_row("sub_5_3", 5, 3, OP_SUB, 1'b1, 1'b0);
        table_rows[3]  = make_row("add_m1_m1", 15, 15, OP_ADD, 1'b1, 1'b0);
        table_rows[4]  = make_row("sra_0", 10, 0, OP_SRA, 1'b1, 1'b0);
        table_rows[5]  = make_row("sra_1", 10, 1, OP_SRA, 1'b1, 1'b0);
        table_rows[6]  = make_row("sra_n_m1", 10, N - 1, OP_SRA, 1'b1, 1'b0);
        table_rows[7]  = make_row("sra_n", 10, N, OP_SRA, 1'b1, 1'b0);
        table_rows[8]  = make_row("sra_big", 5, 9, OP_SRA, 1'b1, 1'b0);
        table_rows[9]  = make_row("srl_0", 10, 0, OP_SRL, 1'b1, 1'b0);
        table_rows[10] = make_row("srl_1", 10, 1, OP_SRL, 1'b1, 1'b0);
        table_rows[11] = make_row("srl_n_m1", 10, N - 1, OP_SRL, 1'b1, 1'b0);
        table_rows[12] = make_row("srl_n", 10, N, OP_SRL, 1'b1, 1'b0);
        table_rows[13] = make_row("unknown_op", 9, 6, 6'b111111, 1'b1, 1'b0);
        // Switch A field differs from the stored 9
        table_rows[14] = make_row("b_only", 15, 3, OP_ADD, 1'b0, 1'b0);
        table_rows[15] = make_row("hold_op", 12, 5, OP_XOR, 1'b1, 1'b1);
        for (int i = NUM_FIXED; i < NUM_ROWS; i++)
        begin
            table_rows[i] = make_row("random", int'($urandom & MASK), int'($urandom & MASK),
                                     op_list[i % 8], 1'b1, 1'b0);
        end

        repeat (2) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            apply_row(table_rows[i]);
        end
        repeat (4) @(negedge clock);
        if (checks != NUM_ROWS)
        begin
            $display("Only %0d of %0d results were checked", checks, NUM_ROWS);
            tb_errors++;
        end
        $display("Checks %0d, checker errors %0d, testbench errors %0d",
                 checks, errors, tb_errors);
        if (errors == 0 && tb_errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
alu_pkg.sv
button_pulse.sv
alu_input_ctrl.sv
alu.sv
alu_board_top.sv
alu_board_checker.sv
tb_alu_board.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_alu_board -f compile.f
	./obj_dir/Vtb_alu_board | awk '{ print } /^Finished with no errors$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
